//--- hw/uart_pkg.sv
// serial packet link definitions

package uart_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int PKT_W      = 64;                // packet with parity bit
    localparam int BODY_W     = PKT_W - 1;         // packet without parity
    localparam int FIFO_BITS  = 11;                // event fifo address width
    localparam int FIFO_DEPTH = 1 << FIFO_BITS;    // 2048 entries
    localparam int BIT_CLKS   = 2;                 // clocks per serial bit
    localparam int PHASE_W    = $clog2(BIT_CLKS);  // clock-within-bit counter
    localparam int BCNT_W     = $clog2(PKT_W + 2); // start + 64 bits + stop
    localparam int PKT_CNT_W  = 16;                // received packet counter

    localparam logic [31:0] CFG_MAGIC = 32'h8950_4E47;

    ////////////////////////////////////////////////////////////
    // packet decode
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        PKT_UNUSED = 2'b00,
        PKT_DATA   = 2'b01,
        PKT_CFG_WR = 2'b10,
        PKT_CFG_RD = 2'b11
    } pkt_type_t;

    // data packet, msb first
    typedef struct packed {
        logic        downstream;   // 62
        logic [1:0]  shared_fifo;  // 61:60 half full / full
        logic [1:0]  local_fifo;   // 59:58
        logic [1:0]  trigger;      // 57:56 normal, ext, cross, periodic
        logic [9:0]  adc;          // 55:46
        logic        cds;          // 45
        logic        reset_sample; // 44
        logic [27:0] timestamp;    // 43:16
        logic [5:0]  channel;      // 15:10
        logic [7:0]  chip_id;      // 9:2
        pkt_type_t   pkt_type;     // 1:0
    } data_pkt_t;

    // configuration packet
    typedef struct packed {
        logic [4:0]  pad;          // 62:58
        logic [31:0] magic;        // 57:26 must read CFG_MAGIC
        logic [7:0]  reg_data;     // 25:18
        logic [7:0]  reg_addr;     // 17:10
        logic [7:0]  chip_id;      // 9:2
        pkt_type_t   pkt_type;     // 1:0
    } cfg_pkt_t;

    // one 63-bit body, two readings selected by pkt_type
    typedef union packed {
        data_pkt_t data;
        cfg_pkt_t  cfg;
    } pkt_body_u;

endpackage

//--- hw/uart_tx.sv
// uart packet transmitter

`timescale 1ns/1ps

module uart_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [uart_pkg::PKT_W-1:0] tx_data,    // parity + body
    input  logic                       ld_tx_data, // load strobe
    input  logic                       tx_enable,
    output logic                       tx_out,
    output logic                       tx_busy
);

    import uart_pkg::*;

    localparam logic [BCNT_W-1:0] LAST_DATA = BCNT_W'(PKT_W);     // index of bit 63
    localparam logic [BCNT_W-1:0] STOP_BIT  = BCNT_W'(PKT_W + 1); // frame end

    logic               active;   // frame in flight
    logic [PKT_W-1:0]   shreg;    // remaining data bits, lsb next
    logic [PHASE_W-1:0] phase;    // clock within current bit
    logic [BCNT_W-1:0]  bit_cnt;  // 0 start, 1..64 data, 65 stop
    logic               bit_end;
    logic               tx_load;
    logic               tx_shift;

    assign bit_end  = active && (phase == PHASE_W'(BIT_CLKS - 1));
    assign tx_load  = !active && ld_tx_data && tx_enable; // ignored when disabled
    assign tx_shift = bit_end && (bit_cnt < LAST_DATA);   // next bit is a data bit

    // disabled link looks busy so the fifo keeps its packets
    assign tx_busy = active | ~tx_enable;

    ////////////////////////////////////////////////////////////
    // frame control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            tx_out  <= 1'b1;   // line idles high
            phase   <= '0;
            bit_cnt <= '0;
        end else if (!active) begin
            phase   <= '0;
            bit_cnt <= '0;
            if (tx_load) begin
                active <= 1'b1;
                tx_out <= 1'b0;  // start bit from next cycle
            end
        end else if (bit_end) begin
            phase   <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == STOP_BIT)
                active <= 1'b0;       // stop bit done
            else if (bit_cnt == LAST_DATA)
                tx_out <= 1'b1;       // stop bit
            else
                tx_out <= shreg[0];   // lsb first
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // payload shift register
    always_ff @(posedge clk) begin
        if (tx_load)
            shreg <= tx_data;
        else if (tx_shift)
            shreg <= {1'b0, shreg[PKT_W-1:1]};
    end

endmodule

//--- hw/uart_rx.sv
// uart packet receiver

`timescale 1ns/1ps

module uart_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx_in,       // serial line from previous chip
    input  logic                rx_enable,   // acts as clock enable
    input  logic                uld_rx_data, // unload strobe
    output uart_pkg::pkt_body_u rx_data,
    output logic                rx_empty,
    output logic                parity_error,
    output logic                rx_done      // one pulse per frame
);

    import uart_pkg::*;

    localparam logic [BCNT_W-1:0] STOP_BIT = BCNT_W'(PKT_W + 1);

    logic [2:0]         rx_sync;   // [1:0] synchronizer, [2] previous value
    logic               rx_bit;    // synchronized line
    logic               active;    // inside a frame
    logic [PHASE_W-1:0] phase;
    logic [BCNT_W-1:0]  bit_cnt;   // 0 start, 1..64 data, 65 stop
    logic [PKT_W-1:0]   shreg;     // collected bits, first bit ends at [0]
    logic               sample;    // second clock of the bit
    logic               start_edge;
    logic               frame_load;

    assign rx_bit     = rx_sync[1];
    assign start_edge = rx_sync[2] & ~rx_sync[1];  // falling edge
    assign sample     = active && (phase == PHASE_W'(BIT_CLKS - 1));
    assign frame_load = rx_enable && sample && (bit_cnt == STOP_BIT);

    ////////////////////////////////////////////////////////////
    // bit timing
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= '1;
            active  <= 1'b0;
            phase   <= '0;
            bit_cnt <= '0;
        end else if (rx_enable) begin
            rx_sync <= {rx_sync[1:0], rx_in};
            if (!active) begin
                if (start_edge) begin
                    active  <= 1'b1;
                    phase   <= PHASE_W'(1);  // edge cycle is clock 0 of start
                    bit_cnt <= '0;
                end
            end else if (sample) begin
                phase   <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == '0 && rx_bit)
                    active <= 1'b0;          // glitch, start bit not low
                else if (bit_cnt == STOP_BIT)
                    active <= 1'b0;          // frame complete
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // data bits arrive lsb first and shift in from the top
    always_ff @(posedge clk) begin
        if (rx_enable && sample && bit_cnt != '0 && bit_cnt != STOP_BIT)
            shreg <= {rx_bit, shreg[PKT_W-1:1]};
    end

    ////////////////////////////////////////////////////////////
    // output holding register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (frame_load)
            rx_data <= shreg[BODY_W-1:0];  // overwrites unread data
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_empty     <= 1'b1;
            parity_error <= 1'b0;
            rx_done      <= 1'b0;
        end else begin
            rx_done <= frame_load;
            if (frame_load) begin
                rx_empty     <= 1'b0;
                parity_error <= ~^shreg;   // odd parity over all 64 bits
            end else if (uld_rx_data) begin
                rx_empty <= 1'b1;
            end
        end
    end

endmodule

//--- hw/uart.sv
// packet link with diagnostics

`timescale 1ns/1ps

module uart (
    input  logic                            clk,
    input  logic                            rst,
    input  uart_pkg::pkt_body_u             fifo_data,   // next event to send
    input  logic                            ld_tx_data,
    input  logic                            rx_in,
    input  logic                            uld_rx_data,
    input  logic                            rx_enable,
    input  logic                            tx_enable,
    input  logic                            enable_fifo_diagnostics,
    input  logic                            enable_packet_diagnostics,
    input  logic [uart_pkg::FIFO_BITS:0]    fifo_counter, // live fill count
    output logic                            tx_out,
    output logic                            tx_busy,
    output logic                            rx_empty,
    output logic                            parity_error,
    output uart_pkg::pkt_body_u             rx_data
);

    import uart_pkg::*;

    pkt_body_u            tx_body;    // body after diagnostic substitution
    logic [PKT_W-1:0]     tx_word;    // parity + body
    logic [PKT_CNT_W-1:0] pkt_count;  // frames received
    logic                 rx_done;

    ////////////////////////////////////////////////////////////
    // transmit word
    ////////////////////////////////////////////////////////////
    always_comb begin
        tx_body = fifo_data;
        if (enable_fifo_diagnostics)
            tx_body.data.timestamp[27:16] = fifo_counter;   // bits 43:32
        else if (enable_packet_diagnostics)
            tx_body.data.local_fifo = pkt_count[1:0];       // bits 59:58
    end

    // odd parity over the body as sent
    assign tx_word = {~^tx_body, tx_body};

    always_ff @(posedge clk) begin
        if (rst)
            pkt_count <= '0;
        else if (rx_done)
            pkt_count <= pkt_count + 1'b1;
    end

    uart_tx i_uart_tx (
        .clk        (clk),
        .rst        (rst),
        .tx_data    (tx_word),
        .ld_tx_data (ld_tx_data),
        .tx_enable  (tx_enable),
        .tx_out     (tx_out),
        .tx_busy    (tx_busy)
    );

    // frames from the previous chip in the chain
    uart_rx i_uart_rx (
        .clk          (clk),
        .rst          (rst),
        .rx_in        (rx_in),
        .rx_enable    (rx_enable),
        .uld_rx_data  (uld_rx_data),
        .rx_data      (rx_data),
        .rx_empty     (rx_empty),
        .parity_error (parity_error),
        .rx_done      (rx_done)
    );

endmodule

//--- hw/event_fifo.sv
// shared event fifo

`timescale 1ns/1ps

module event_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         event_valid,  // write strobe
    input  logic                         tx_busy,
    input  uart_pkg::pkt_body_u          event_pkt,
    output uart_pkg::pkt_body_u          fifo_data,    // word for the link
    output logic                         ld_tx_data,   // launch pulse
    output logic                         fifo_full,
    output logic [uart_pkg::FIFO_BITS:0] fifo_counter
);

    import uart_pkg::*;

    pkt_body_u            mem [FIFO_DEPTH];
    logic [FIFO_BITS-1:0] wr_ptr;
    logic [FIFO_BITS-1:0] rd_ptr;
    logic                 fifo_empty;
    logic                 push;
    logic                 launch;

    assign fifo_empty = (fifo_counter == '0);
    assign fifo_full  = (fifo_counter == (FIFO_BITS + 1)'(FIFO_DEPTH));
    assign push       = event_valid & ~fifo_full;  // full drops the event

    // no back-to-back pulses, tx_busy lags the load by one cycle
    assign launch = ~fifo_empty & ~tx_busy & ~ld_tx_data;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= event_pkt;
    end

    always_ff @(posedge clk) begin
        if (launch)
            fifo_data <= mem[rd_ptr];  // valid with the pulse
    end

    ////////////////////////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////////////////////////
    // the read side advances during the pulse so the
    // count seen by the link still includes this word
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_counter <= '0;
            ld_tx_data   <= 1'b0;
        end else begin
            ld_tx_data <= launch;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            if (ld_tx_data)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, ld_tx_data})
                2'b10:   fifo_counter <= fifo_counter + 1'b1;
                2'b01:   fifo_counter <= fifo_counter - 1'b1;
                default: fifo_counter <= fifo_counter;  // none or both
            endcase
        end
    end

endmodule

//--- hw/chip_io.sv
// chip serial io top

`timescale 1ns/1ps

module chip_io (
    input  logic                clk,
    input  logic                rst,
    input  logic                event_valid,
    input  uart_pkg::pkt_body_u event_pkt,
    input  logic                rx_in,
    input  logic                uld_rx_data,
    input  logic                rx_enable,
    input  logic                tx_enable,
    input  logic                enable_fifo_diagnostics,
    input  logic                enable_packet_diagnostics,
    output logic                tx_out,
    output logic                tx_busy,
    output uart_pkg::pkt_body_u rx_data,
    output logic                rx_empty,
    output logic                parity_error,
    output logic                fifo_full
);

    import uart_pkg::*;

    pkt_body_u          fifo_data;     // popped event
    logic               ld_tx_data;    // fifo launch into tx
    logic [FIFO_BITS:0] fifo_counter;

    event_fifo i_event_fifo (
        .clk          (clk),
        .rst          (rst),
        .event_valid  (event_valid),
        .tx_busy      (tx_busy),
        .event_pkt    (event_pkt),
        .fifo_data    (fifo_data),
        .ld_tx_data   (ld_tx_data),
        .fifo_full    (fifo_full),
        .fifo_counter (fifo_counter)
    );

    uart i_uart (
        .clk                       (clk),
        .rst                       (rst),
        .fifo_data                 (fifo_data),
        .ld_tx_data                (ld_tx_data),
        .rx_in                     (rx_in),
        .uld_rx_data               (uld_rx_data),
        .rx_enable                 (rx_enable),
        .tx_enable                 (tx_enable),
        .enable_fifo_diagnostics   (enable_fifo_diagnostics),
        .enable_packet_diagnostics (enable_packet_diagnostics),
        .fifo_counter              (fifo_counter),
        .tx_out                    (tx_out),
        .tx_busy                   (tx_busy),
        .rx_empty                  (rx_empty),
        .parity_error              (parity_error),
        .rx_data                   (rx_data)
    );

endmodule

//--- bench/tb_chip_io_assert.sv
// link frame and flag assertions

`timescale 1ns/1ps

module tb_chip_io_assert (
    input logic clk,
    input logic rst,
    input logic ld_tx_data,
    input logic tx_enable,
    input logic tx_out,
    input logic tx_busy,
    input logic uld_rx_data,
    input logic frame_load,
    input logic rx_empty
);

    int fail_count = 0;  // read by the testbench at the end

    // accepted load puts the start bit out next cycle
    start_after_load: assert property (@(posedge clk) disable iff (rst)
        ld_tx_data && tx_enable && !tx_busy |=> !tx_out && tx_busy)
        else begin
            fail_count++;
            $error("no start bit after a load");
        end

    idle_high: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> tx_out)   // line idles high
        else begin
            fail_count++;
            $error("tx_out low while the transmitter is idle");
        end

    // a new frame in the same cycle keeps the register full
    empty_after_unload: assert property (@(posedge clk) disable iff (rst)
        uld_rx_data && !frame_load |=> rx_empty)
        else begin
            fail_count++;
            $error("rx_empty did not rise after unload");
        end

endmodule

bind uart_tx tb_chip_io_assert i_tx_assert (
    .clk         (clk),
    .rst         (rst),
    .ld_tx_data  (ld_tx_data),
    .tx_enable   (tx_enable),
    .tx_out      (tx_out),
    .tx_busy     (tx_busy),
    .uld_rx_data (1'b0),
    .frame_load  (1'b0),
    .rx_empty    (1'b1)
);

bind uart_rx tb_chip_io_assert i_rx_assert (
    .clk         (clk),
    .rst         (rst),
    .ld_tx_data  (1'b0),
    .tx_enable   (1'b0),
    .tx_out      (1'b1),
    .tx_busy     (1'b1),
    .uld_rx_data (uld_rx_data),
    .frame_load  (frame_load),
    .rx_empty    (rx_empty)
);

//--- bench/tb_chip_io.sv
// chip io testbench

`timescale 1ns/1ps

module tb_chip_io;

    import uart_pkg::*;

    localparam int FRAME_CYCLES = 140;  // 66 bits x 2 clocks plus launch and sync
    localparam int MAX_FRAMES   = 10;   // per test
    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_LIMIT  = NUM_TESTS * MAX_FRAMES * FRAME_CYCLES;

    logic      clk;
    logic      rst;
    logic      event_valid;
    pkt_body_u event_pkt;
    logic      rx_in;
    logic      uld_rx_data;
    logic      rx_enable;
    logic      tx_enable;
    logic      enable_fifo_diagnostics;
    logic      enable_packet_diagnostics;
    logic      tx_out;
    logic      tx_busy;
    pkt_body_u rx_data;
    logic      rx_empty;
    logic      parity_error;
    logic      fifo_full;

    logic      loopback;        // selects tx_out or the serial driver for rx_in
    logic      drv_line;        // serial driver output
    int        seed;
    int        errors = 0;
    int        frames_seen = 0; // frames unloaded from the receiver
    int        cycles = 0;

    assign rx_in = loopback ? tx_out : drv_line;

    chip_io i_dut (
        .clk                       (clk),
        .rst                       (rst),
        .event_valid               (event_valid),
        .event_pkt                 (event_pkt),
        .rx_in                     (rx_in),
        .uld_rx_data               (uld_rx_data),
        .rx_enable                 (rx_enable),
        .tx_enable                 (tx_enable),
        .enable_fifo_diagnostics   (enable_fifo_diagnostics),
        .enable_packet_diagnostics (enable_packet_diagnostics),
        .tx_out                    (tx_out),
        .tx_busy                   (tx_busy),
        .rx_data                   (rx_data),
        .rx_empty                  (rx_empty),
        .parity_error              (parity_error),
        .fifo_full                 (fifo_full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // watchdog
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic tick();
        @(posedge clk);
        #1;                     // drive and sample away from the edge
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("ERROR %s got %h expected %h", name, got, exp);
    endtask

    // body plus parity bit holds an odd number of ones
    function automatic logic odd_parity(input logic [BODY_W-1:0] body);
        return ~^body;
    endfunction

    // bits 43:32 replaced by the fifo count
    function automatic pkt_body_u with_fifo_count(input pkt_body_u p,
                                                  input logic [FIFO_BITS:0] count);
        logic [BODY_W-1:0] w;
        w = p;
        w[43:32] = count;
        return w;
    endfunction

    // bits 59:58 replaced by the received frame count
    function automatic pkt_body_u with_frame_count(input pkt_body_u p, input logic [1:0] n);
        logic [BODY_W-1:0] w;
        w = p;
        w[59:58] = n;
        return w;
    endfunction

    function automatic pkt_body_u rand_data_pkt();
        pkt_body_u   p;
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        p = {r1[30:0], r0};
        p.data.pkt_type = PKT_DATA;
        return p;
    endfunction

    task automatic push_event(input pkt_body_u p);
        event_pkt   = p;
        event_valid = 1'b1;     // one-cycle write strobe
        tick();
        event_valid = 1'b0;
    endtask

    task automatic wait_frame(output logic ok);
        int n;
        n = 0;
        while (rx_empty && n < 2 * FRAME_CYCLES) begin
            tick();
            n++;
        end
        ok = !rx_empty;
        if (!ok) begin
            errors++;
            $display("no frame reached the receiver in time");
        end
    endtask

    task automatic unload_frame();
        frames_seen++;
        uld_rx_data = 1'b1;
        tick();
        uld_rx_data = 1'b0;
        if (rx_empty !== 1'b1)
            report_mismatch("rx_empty", 64'(rx_empty), 64'd1);
    endtask

    task automatic expect_frame(input pkt_body_u exp, input logic exp_perr);
        logic ok;
        wait_frame(ok);
        if (ok) begin
            if (rx_data !== exp)
                report_mismatch("rx_data", {1'b0, rx_data}, {1'b0, exp});
            if (parity_error !== exp_perr)
                report_mismatch("parity_error", 64'(parity_error), 64'(exp_perr));
            unload_frame();
        end
    endtask

    // start, 64 bits lsb first, stop
    task automatic send_serial(input logic [PKT_W-1:0] word);
        drv_line = 1'b0;
        repeat (BIT_CLKS) tick();
        for (int i = 0; i < PKT_W; i++) begin
            drv_line = word[i];
            repeat (BIT_CLKS) tick();
        end
        drv_line = 1'b1;
        repeat (BIT_CLKS) tick();
    endtask

    task automatic count_tx_low(input int n, output int low);
        low = 0;
        repeat (n) begin
            tick();
            if (tx_out !== 1'b1)
                low++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////
    task automatic reset_state();
        if (tx_out !== 1'b1)       report_mismatch("tx_out", 64'(tx_out), 64'd1);
        if (tx_busy !== 1'b0)      report_mismatch("tx_busy", 64'(tx_busy), 64'd0);
        if (rx_empty !== 1'b1)     report_mismatch("rx_empty", 64'(rx_empty), 64'd1);
        if (fifo_full !== 1'b0)    report_mismatch("fifo_full", 64'(fifo_full), 64'd0);
        if (parity_error !== 1'b0) report_mismatch("parity_error", 64'(parity_error), 64'd0);
    endtask

    task automatic data_loopback();
        pkt_body_u sent[$];
        pkt_body_u p;
        for (int i = 0; i < 3; i++) begin
            p = rand_data_pkt();
            sent.push_back(p);
            push_event(p);
        end
        while (sent.size() > 0)
            expect_frame(sent.pop_front(), 1'b0);  // write order
    endtask

    task automatic config_view();
        pkt_body_u   p;
        logic [31:0] r;
        logic        ok;
        r = $random(seed);
        p = '0;
        p.cfg.pkt_type = PKT_CFG_WR;
        p.cfg.chip_id  = r[23:16];
        p.cfg.reg_addr = r[7:0];
        p.cfg.reg_data = r[15:8];
        p.cfg.magic    = CFG_MAGIC;
        push_event(p);
        wait_frame(ok);
        if (ok) begin
            if (rx_data.cfg.pkt_type !== PKT_CFG_WR)
                report_mismatch("cfg.pkt_type", 64'(rx_data.cfg.pkt_type), 64'(PKT_CFG_WR));
            if (rx_data.cfg.magic !== CFG_MAGIC)
                report_mismatch("cfg.magic", 64'(rx_data.cfg.magic), 64'(CFG_MAGIC));
            if (rx_data.cfg.chip_id !== r[23:16])
                report_mismatch("cfg.chip_id", 64'(rx_data.cfg.chip_id), 64'(r[23:16]));
            if (rx_data.cfg.reg_addr !== r[7:0])
                report_mismatch("cfg.reg_addr", 64'(rx_data.cfg.reg_addr), 64'(r[7:0]));
            if (rx_data.cfg.reg_data !== r[15:8])
                report_mismatch("cfg.reg_data", 64'(rx_data.cfg.reg_data), 64'(r[15:8]));
            if (parity_error !== 1'b0)
                report_mismatch("parity_error", 64'(parity_error), 64'd0);
            unload_frame();
        end
    endtask

    task automatic fifo_diagnostics();
        pkt_body_u sent[$];
        pkt_body_u p;
        int        n;
        tx_enable = 1'b0;               // hold packets in the fifo
        enable_fifo_diagnostics = 1'b1;
        for (int i = 0; i < 4; i++) begin
            p = rand_data_pkt();
            sent.push_back(p);
            push_event(p);
        end
        tx_enable = 1'b1;
        n = 4;                          // count at each launch falls from 4 to 1
        while (sent.size() > 0) begin
            expect_frame(with_fifo_count(sent.pop_front(), 12'(n)), 1'b0);
            n--;
        end
        enable_fifo_diagnostics = 1'b0;
    endtask

    task automatic packet_diagnostics();
        pkt_body_u p;
        enable_packet_diagnostics = 1'b1;
        for (int i = 0; i < 3; i++) begin  // one at a time so the count has settled
            p = rand_data_pkt();
            push_event(p);
            expect_frame(with_frame_count(p, 2'(frames_seen)), 1'b0);
        end
        enable_packet_diagnostics = 1'b0;
    endtask

    task automatic parity_error_frame();
        pkt_body_u p;
        int        low;
        p = rand_data_pkt();
        tx_enable = 1'b0;
        push_event(rand_data_pkt());    // stays queued
        loopback = 1'b0;
        fork
            send_serial({~odd_parity(p), p});  // even parity on the line
            count_tx_low(FRAME_CYCLES, low);
        join
        if (low != 0) begin
            errors++;
            $display("tx_out left idle for %0d cycles with the transmitter disabled", low);
        end
        expect_frame(p, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed                      = 32'h3bbe;
        rst                       = 1'b1;
        event_valid               = 1'b0;
        event_pkt                 = '0;
        uld_rx_data               = 1'b0;
        rx_enable                 = 1'b1;
        tx_enable                 = 1'b1;
        enable_fifo_diagnostics   = 1'b0;
        enable_packet_diagnostics = 1'b0;
        loopback                  = 1'b1;
        drv_line                  = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        reset_state();
        data_loopback();
        config_view();
        fifo_diagnostics();
        packet_diagnostics();
        parity_error_frame();
        tick();

        errors += i_dut.i_uart.i_uart_tx.i_tx_assert.fail_count;
        errors += i_dut.i_uart.i_uart_rx.i_rx_assert.fail_count;
        $display("errors %0d, frames received %0d", errors, frames_seen);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- files.f
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart.sv
hw/event_fifo.sv
hw/chip_io.sv
bench/tb_chip_io_assert.sv
bench/tb_chip_io.sv

//--- Makefile
# Verilator build and run of the chip io testbench

TOP = tb_chip_io
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
